// ==== Bender.yml ====
package:
  name: gfx_line

sources:
  - gfx_cmd_pkg.sv
  - gfx_fb_pkg.sv
  - gfx_job_if.sv
  - gfx_pix_if.sv
  - gfx_cmd_decode.sv
  - gfx_line_raster.sv
  - gfx_fb_writer.sv
  - gfx_line_top.sv
  - target: simulation
    files:
      - gfx_line_assertions.sv
      - gfx_line_tb.sv

// ==== gfx_cmd_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module gfx_cmd_decode #(
  parameter int H_WIDTH     = gfx_fb_pkg::H_WIDTH_DEF,
  parameter int V_WIDTH     = gfx_fb_pkg::V_WIDTH_DEF,
  parameter int PIXEL_WIDTH = gfx_fb_pkg::PIXEL_WIDTH_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  gfx_cmd_pkg::opcode_t   cmd_op,
  input  logic [H_WIDTH-1:0]     cmd_x0,
  input  logic [V_WIDTH-1:0]     cmd_y0,
  input  logic [H_WIDTH-1:0]     cmd_x1,
  input  logic [V_WIDTH-1:0]     cmd_y1,
  input  logic [PIXEL_WIDTH-1:0] cmd_color,
  output logic [7:0]             err_count,
  gfx_job_if.src                 job
);

  logic cmd_accept;
  logic cmd_legal;
  logic cmd_point;
  logic cmd_xor;

  // Single job slot, a new command only when it is empty
  assign cmd_ready  = !job.valid;
  assign cmd_accept = cmd_valid && cmd_ready;

  always_comb begin
    cmd_legal = 1'b1;
    cmd_point = 1'b0;
    cmd_xor   = 1'b0;
    case (cmd_op)
      gfx_cmd_pkg::OP_POINT: begin
        cmd_point = 1'b1;
      end
      gfx_cmd_pkg::OP_LINE: begin
        cmd_point = 1'b0;
      end
      gfx_cmd_pkg::OP_POINT_XOR: begin
        cmd_point = 1'b1;
        cmd_xor   = 1'b1;
      end
      gfx_cmd_pkg::OP_LINE_XOR: begin
        cmd_xor = 1'b1;
      end
      default: begin
        cmd_legal = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      job.valid <= 1'b0;
      err_count <= 8'd0;
    end else begin
      if (job.valid && job.ready) begin
        job.valid <= 1'b0;
      end
      if (cmd_accept) begin
        if (cmd_legal) begin
          job.valid <= 1'b1;
        end else if (err_count != 8'hff) begin
          err_count <= err_count + 8'd1;
        end
      end
    end
  end

  // A point is a line whose endpoints coincide
  always_ff @(posedge clk) begin
    if (cmd_accept && cmd_legal) begin
      job.x0    <= cmd_x0;
      job.y0    <= cmd_y0;
      job.x1    <= cmd_point ? cmd_x0 : cmd_x1;
      job.y1    <= cmd_point ? cmd_y0 : cmd_y1;
      job.color <= cmd_color;
      job.mode  <= cmd_xor ? gfx_fb_pkg::WR_XOR : gfx_fb_pkg::WR_SET;
    end
  end

endmodule

`default_nettype wire

// ==== gfx_cmd_pkg.sv ====
`default_nettype none

package gfx_cmd_pkg;

  // Legal command opcodes
  // The remaining 3-bit encodings are illegal
  typedef enum logic [2:0] {
    OP_POINT     = 3'd0,
    OP_LINE      = 3'd1,
    OP_POINT_XOR = 3'd2,
    OP_LINE_XOR  = 3'd3
  } opcode_t;

  // Rasteriser FSM states
  // ST_DRAW emits inner pixels and ST_LAST emits the final endpoint
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_SETUP = 2'd1,
    ST_DRAW  = 2'd2,
    ST_LAST  = 2'd3
  } raster_state_t;

endpackage

`default_nettype wire

// ==== gfx_fb_pkg.sv ====
`default_nettype none

package gfx_fb_pkg;

  // How a pixel lands in the framebuffer
  typedef enum logic {
    WR_SET = 1'b0,
    WR_XOR = 1'b1
  } wr_mode_t;

  // Default framebuffer geometry, 64 x 32 pixels of 8 bits
  localparam int H_WIDTH_DEF     = 6;
  localparam int V_WIDTH_DEF     = 5;
  localparam int PIXEL_WIDTH_DEF = 8;

endpackage

`default_nettype wire

// ==== gfx_fb_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module gfx_fb_writer #(
  parameter int H_WIDTH     = gfx_fb_pkg::H_WIDTH_DEF,
  parameter int V_WIDTH     = gfx_fb_pkg::V_WIDTH_DEF,
  parameter int PIXEL_WIDTH = gfx_fb_pkg::PIXEL_WIDTH_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,
  gfx_pix_if.dst                 pix,
  input  logic [H_WIDTH-1:0]     rd_x,
  input  logic [V_WIDTH-1:0]     rd_y,
  output logic [PIXEL_WIDTH-1:0] rd_data,
  output logic [15:0]            pix_count
);

  localparam int AW    = H_WIDTH + V_WIDTH;
  localparam int DEPTH = 1 << AW;

  logic [PIXEL_WIDTH-1:0] mem [DEPTH];

  logic [AW-1:0]          pix_addr;
  logic                   pix_fire;
  logic                   pix_xor;

  // Second phase of an XOR write
  logic                   rmw_busy;
  logic [AW-1:0]          rmw_addr;
  logic [PIXEL_WIDTH-1:0] rmw_pixel;
  logic [PIXEL_WIDTH-1:0] rmw_old;

  logic                   wr_en;
  logic [AW-1:0]          wr_addr;
  logic [PIXEL_WIDTH-1:0] wr_data;

  assign pix.ready = !rmw_busy;
  assign pix_addr  = {pix.y, pix.x};
  assign pix_fire  = pix.valid && pix.ready;
  assign pix_xor   = pix.mode == gfx_fb_pkg::WR_XOR;

  // Single write port shared by SET writes and XOR write-back
  assign wr_en   = rmw_busy || (pix_fire && !pix_xor);
  assign wr_addr = rmw_busy ? rmw_addr : pix_addr;
  assign wr_data = rmw_busy ? (rmw_old ^ rmw_pixel) : pix.pixel;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rmw_busy  <= 1'b0;
      pix_count <= 16'd0;
    end else begin
      if (rmw_busy) begin
        rmw_busy <= 1'b0;
      end else if (pix_fire && pix_xor) begin
        rmw_busy <= 1'b1;
      end
      if (wr_en) begin
        pix_count <= pix_count + 16'd1;
      end
    end
  end

  // Old value captured on the accept edge
  always_ff @(posedge clk) begin
    if (pix_fire && pix_xor) begin
      rmw_addr  <= pix_addr;
      rmw_pixel <= pix.pixel;
      rmw_old   <= mem[pix_addr];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Observation port, returns the value before any same-cycle write
  always_ff @(posedge clk) begin
    rd_data <= mem[{rd_y, rd_x}];
  end

endmodule

`default_nettype wire

// ==== gfx_job_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Decoded raster job, one line between two endpoints
interface gfx_job_if #(
  parameter int H_WIDTH     = gfx_fb_pkg::H_WIDTH_DEF,
  parameter int V_WIDTH     = gfx_fb_pkg::V_WIDTH_DEF,
  parameter int PIXEL_WIDTH = gfx_fb_pkg::PIXEL_WIDTH_DEF
);

  logic                   valid;
  logic                   ready;
  logic [H_WIDTH-1:0]     x0;
  logic [V_WIDTH-1:0]     y0;
  logic [H_WIDTH-1:0]     x1;
  logic [V_WIDTH-1:0]     y1;
  logic [PIXEL_WIDTH-1:0] color;
  gfx_fb_pkg::wr_mode_t   mode;

  modport src (
    output valid, x0, y0, x1, y1, color, mode,
    input  ready
  );

  modport dst (
    input  valid, x0, y0, x1, y1, color, mode,
    output ready
  );

endinterface

`default_nettype wire

// ==== gfx_line_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module gfx_line_assertions #(
  parameter int H_WIDTH     = gfx_fb_pkg::H_WIDTH_DEF,
  parameter int V_WIDTH     = gfx_fb_pkg::V_WIDTH_DEF,
  parameter int PIXEL_WIDTH = gfx_fb_pkg::PIXEL_WIDTH_DEF
) (
  input logic                                         clk,
  input logic                                         rst_n,
  input logic                                         cmd_ready,
  input logic                                         job_valid,
  input logic                                         job_ready,
  input logic [2*H_WIDTH+2*V_WIDTH+PIXEL_WIDTH:0]     job_data,
  input logic                                         pix_valid,
  input logic                                         pix_ready,
  input logic [H_WIDTH+V_WIDTH+PIXEL_WIDTH:0]         pix_data,
  input gfx_cmd_pkg::raster_state_t                   raster_state
);

  // Number of failed assertions
  int fail_count;

  initial begin
    fail_count = 0;
  end

  // Job slot is empty once reset is released
  reset_ready: assert property (@(posedge clk) !rst_n |=> cmd_ready)
    else begin
      fail_count++;
      $error("cmd_ready is low in the cycle after reset");
    end

  job_hold: assert property (@(posedge clk) disable iff (!rst_n)
    job_valid && !job_ready |=> job_valid && $stable(job_data))
    else begin
      fail_count++;
      $error("Job valid or job fields changed before ready");
    end

  pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable(pix_data))
    else begin
      fail_count++;
      $error("Pixel valid or pixel fields changed before ready");
    end

  // Idle and the cycle right after it never carry a pixel
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    raster_state == gfx_cmd_pkg::ST_IDLE |-> !pix_valid ##1 !pix_valid)
    else begin
      fail_count++;
      $error("Pixel valid is high while or right after the rasteriser is idle");
    end

endmodule

bind gfx_line_top gfx_line_assertions #(
  .H_WIDTH    (H_WIDTH),
  .V_WIDTH    (V_WIDTH),
  .PIXEL_WIDTH(PIXEL_WIDTH)
) gfx_line_assertions_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .cmd_ready   (cmd_ready),
  .job_valid   (job_if.valid),
  .job_ready   (job_if.ready),
  .job_data    ({job_if.x0, job_if.y0, job_if.x1, job_if.y1, job_if.color, job_if.mode}),
  .pix_valid   (pix_if.valid),
  .pix_ready   (pix_if.ready),
  .pix_data    ({pix_if.x, pix_if.y, pix_if.pixel, pix_if.mode}),
  .raster_state(gfx_line_raster_i.state)
);

`default_nettype wire

// ==== gfx_line_raster.sv ====
`timescale 1ns/10ps
`default_nettype none

module gfx_line_raster #(
  parameter int H_WIDTH     = gfx_fb_pkg::H_WIDTH_DEF,
  parameter int V_WIDTH     = gfx_fb_pkg::V_WIDTH_DEF,
  parameter int PIXEL_WIDTH = gfx_fb_pkg::PIXEL_WIDTH_DEF
) (
  input  logic   clk,
  input  logic   rst_n,
  gfx_job_if.dst job,
  gfx_pix_if.src pix
);

  // Coordinates are walked in major/minor form, wide enough for either axis
  localparam int CW = (H_WIDTH > V_WIDTH) ? H_WIDTH : V_WIDTH;

  gfx_cmd_pkg::raster_state_t state;

  // Job copy, the decode slot is freed on accept
  logic [H_WIDTH-1:0]     x0_q;
  logic [V_WIDTH-1:0]     y0_q;
  logic [H_WIDTH-1:0]     x1_q;
  logic [V_WIDTH-1:0]     y1_q;
  logic [PIXEL_WIDTH-1:0] color_q;
  gfx_fb_pkg::wr_mode_t   mode_q;

  logic [CW-1:0]          dist_x;
  logic [CW-1:0]          dist_y;
  logic                   steep_c;
  logic [CW-1:0]          d_maj_c;

  logic                   steep;
  logic                   step_maj_up;
  logic                   step_min_up;
  logic [CW-1:0]          cur_maj;
  logic [CW-1:0]          cur_min;
  logic [CW-1:0]          end_maj;
  logic [CW-1:0]          d_maj;
  logic [CW-1:0]          d_min;
  logic signed [CW+1:0]   err;

  logic signed [CW+1:0]   err_step;
  logic [CW-1:0]          maj_next;
  logic [CW-1:0]          min_next;
  logic                   last_pixel;
  logic                   job_fire;
  logic                   pix_fire;

  // Setup terms from the latched endpoints
  assign dist_x  = (x1_q >= x0_q) ? CW'(x1_q - x0_q) : CW'(x0_q - x1_q);
  assign dist_y  = (y1_q >= y0_q) ? CW'(y1_q - y0_q) : CW'(y0_q - y1_q);
  assign steep_c = dist_y > dist_x;
  assign d_maj_c = steep_c ? dist_y : dist_x;

  // One Bresenham step
  assign err_step   = err - $signed({2'b00, d_min});
  assign maj_next   = step_maj_up ? cur_maj + 1'b1 : cur_maj - 1'b1;
  assign min_next   = step_min_up ? cur_min + 1'b1 : cur_min - 1'b1;
  assign last_pixel = maj_next == end_maj;

  assign job.ready = state == gfx_cmd_pkg::ST_IDLE;
  assign job_fire  = job.valid && job.ready;

  assign pix.valid = (state == gfx_cmd_pkg::ST_DRAW) || (state == gfx_cmd_pkg::ST_LAST);
  assign pix.x     = steep ? cur_min[H_WIDTH-1:0] : cur_maj[H_WIDTH-1:0];
  assign pix.y     = steep ? cur_maj[V_WIDTH-1:0] : cur_min[V_WIDTH-1:0];
  assign pix.pixel = color_q;
  assign pix.mode  = mode_q;
  assign pix_fire  = pix.valid && pix.ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= gfx_cmd_pkg::ST_IDLE;
    end else begin
      case (state)
        gfx_cmd_pkg::ST_IDLE: begin
          if (job_fire) state <= gfx_cmd_pkg::ST_SETUP;
        end
        gfx_cmd_pkg::ST_SETUP: begin
          // Zero major distance means a single pixel
          state <= (d_maj_c == '0) ? gfx_cmd_pkg::ST_LAST : gfx_cmd_pkg::ST_DRAW;
        end
        gfx_cmd_pkg::ST_DRAW: begin
          if (pix_fire && last_pixel) state <= gfx_cmd_pkg::ST_LAST;
        end
        gfx_cmd_pkg::ST_LAST: begin
          if (pix_fire) state <= gfx_cmd_pkg::ST_IDLE;
        end
        default: state <= gfx_cmd_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (job_fire) begin
      x0_q    <= job.x0;
      y0_q    <= job.y0;
      x1_q    <= job.x1;
      y1_q    <= job.y1;
      color_q <= job.color;
      mode_q  <= job.mode;
    end

    if (state == gfx_cmd_pkg::ST_SETUP) begin
      steep <= steep_c;
      d_maj <= d_maj_c;
      d_min <= steep_c ? dist_x : dist_y;
      err   <= $signed({2'b00, d_maj_c >> 1});
      if (steep_c) begin
        cur_maj     <= CW'(y0_q);
        cur_min     <= CW'(x0_q);
        end_maj     <= CW'(y1_q);
        step_maj_up <= y1_q >= y0_q;
        step_min_up <= x1_q >= x0_q;
      end else begin
        cur_maj     <= CW'(x0_q);
        cur_min     <= CW'(y0_q);
        end_maj     <= CW'(x1_q);
        step_maj_up <= x1_q >= x0_q;
        step_min_up <= y1_q >= y0_q;
      end
    end

    // Advance on each accepted inner pixel
    if (state == gfx_cmd_pkg::ST_DRAW && pix_fire) begin
      cur_maj <= maj_next;
      if (err_step < 0) begin
        cur_min <= min_next;
        err     <= err_step + $signed({2'b00, d_maj});
      end else begin
        err <= err_step;
      end
    end
  end

endmodule

`default_nettype wire

// ==== gfx_line_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gfx_line_tb;

  localparam int HW      = gfx_fb_pkg::H_WIDTH_DEF;
  localparam int VW      = gfx_fb_pkg::V_WIDTH_DEF;
  localparam int PW      = gfx_fb_pkg::PIXEL_WIDTH_DEF;
  localparam int DEPTH   = 1 << (HW + VW);
  localparam int TIMEOUT = 2000;

  logic                 clk;
  logic                 rst_n;
  logic                 cmd_valid;
  logic                 cmd_ready;
  gfx_cmd_pkg::opcode_t cmd_op;
  logic [HW-1:0]        cmd_x0;
  logic [VW-1:0]        cmd_y0;
  logic [HW-1:0]        cmd_x1;
  logic [VW-1:0]        cmd_y1;
  logic [PW-1:0]        cmd_color;
  logic [HW-1:0]        rd_x;
  logic [VW-1:0]        rd_y;
  logic [PW-1:0]        rd_data;
  logic [15:0]          pix_count;
  logic [7:0]           err_count;

  // Reference framebuffer and expected counters
  logic [PW-1:0]        model_fb [DEPTH];
  int                   exp_pix;
  int                   exp_err;
  logic [31:0]          rng_state;

  gfx_line_top #(
    .H_WIDTH    (HW),
    .V_WIDTH    (VW),
    .PIXEL_WIDTH(PW)
  ) gfx_line_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_op   (cmd_op),
    .cmd_x0   (cmd_x0),
    .cmd_y0   (cmd_y0),
    .cmd_x1   (cmd_x1),
    .cmd_y1   (cmd_y1),
    .cmd_color(cmd_color),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_data  (rd_data),
    .pix_count(pix_count),
    .err_count(err_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic roll(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // Concurrent assertion failures end the run at once
  always @(negedge clk) begin
    assert (gfx_line_top_i.gfx_line_assertions_i.fail_count == 0) else begin
      $display("A concurrent assertion failed at time %0t", $time);
      abort_run();
    end
  end

  // Bresenham walk including both endpoints
  task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                            input logic [PW-1:0] color, input logic use_xor);
    int   dx;
    int   dy;
    int   dmaj;
    int   dmin;
    int   maj;
    int   mnr;
    int   smaj;
    int   smin;
    int   err;
    int   addr;
    logic steep;
    dx    = (x1 >= x0) ? x1 - x0 : x0 - x1;
    dy    = (y1 >= y0) ? y1 - y0 : y0 - y1;
    steep = dy > dx;
    dmaj  = steep ? dy : dx;
    dmin  = steep ? dx : dy;
    maj   = steep ? y0 : x0;
    mnr   = steep ? x0 : y0;
    smaj  = steep ? ((y1 >= y0) ? 1 : -1) : ((x1 >= x0) ? 1 : -1);
    smin  = steep ? ((x1 >= x0) ? 1 : -1) : ((y1 >= y0) ? 1 : -1);
    err   = dmaj / 2;
    for (int i = 0; i <= dmaj; i++) begin
      addr = steep ? (maj << HW) + mnr : (mnr << HW) + maj;
      if (use_xor) begin
        model_fb[addr] = model_fb[addr] ^ color;
      end else begin
        model_fb[addr] = color;
      end
      err = err - dmin;
      if (err < 0) begin
        mnr = mnr + smin;
        err = err + dmaj;
      end
      maj = maj + smaj;
    end
    exp_pix = exp_pix + dmaj + 1;
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic issue_cmd(input gfx_cmd_pkg::opcode_t op, input int x0, input int y0,
                           input int x1, input int y1, input logic [PW-1:0] color);
    int   waited;
    logic legal;
    cmd_op    = op;
    cmd_x0    = HW'(x0);
    cmd_y0    = VW'(y0);
    cmd_x1    = HW'(x1);
    cmd_y1    = VW'(y1);
    cmd_color = color;
    cmd_valid = 1'b1;
    waited    = 0;
    while (!cmd_ready) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timed out waiting for cmd_ready");
        abort_run();
      end
    end
    @(negedge clk);
    legal = 1'b1;
    case (op)
      gfx_cmd_pkg::OP_POINT:     model_line(x0, y0, x0, y0, color, 1'b0);
      gfx_cmd_pkg::OP_LINE:      model_line(x0, y0, x1, y1, color, 1'b0);
      gfx_cmd_pkg::OP_POINT_XOR: model_line(x0, y0, x0, y0, color, 1'b1);
      gfx_cmd_pkg::OP_LINE_XOR:  model_line(x0, y0, x1, y1, color, 1'b1);
      default: begin
        legal = 1'b0;
        exp_err++;
      end
    endcase
    // A legal command is held as a job and closes the port
    check_value("cmd_ready", 32'(cmd_ready), 32'(!legal));
  endtask

  task automatic wait_drawn();
    int waited;
    cmd_valid = 1'b0;
    waited    = 0;
    while (pix_count !== 16'(exp_pix)) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Timed out waiting for pix_count to reach the expected total");
        abort_run();
      end
    end
    check_value("err_count", err_count, 32'(exp_err));
  endtask

  // Full read-back at one address per cycle
  task automatic compare_framebuffer();
    for (int a = 0; a < DEPTH; a++) begin
      rd_x = a[HW-1:0];
      rd_y = a[HW+VW-1:HW];
      @(negedge clk);
      check_value($sformatf("rd_data at x 0x%0h y 0x%0h", rd_x, rd_y), rd_data, model_fb[a]);
    end
    check_value("pix_count", pix_count, 32'(exp_pix[15:0]));
  endtask

  initial begin
    logic [31:0]          r;
    int                   x0;
    int                   y0;
    int                   x1;
    int                   y1;
    int                   len;
    int                   mnr;
    gfx_cmd_pkg::opcode_t op;
    rng_state = 32'h8707_8fbb;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = gfx_cmd_pkg::OP_POINT;
    cmd_x0    = '0;
    cmd_y0    = '0;
    cmd_x1    = '0;
    cmd_y1    = '0;
    cmd_color = '0;
    rd_x      = '0;
    rd_y      = '0;
    exp_pix   = 0;
    exp_err   = 0;
    foreach (model_fb[i]) model_fb[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Clear every pixel and then cancel an XOR line drawn twice
    for (int a = 0; a < DEPTH; a++) begin
      issue_cmd(gfx_cmd_pkg::OP_POINT, a % (1 << HW), a >> HW, 0, 0, '0);
    end
    wait_drawn();
    compare_framebuffer();
    roll(r);
    for (int k = 0; k < 2; k++) begin
      issue_cmd(gfx_cmd_pkg::OP_LINE_XOR, r[5:0], r[12:8], r[21:16], r[28:24], 8'h5a);
      cmd_valid = 1'b0;
      @(negedge clk);
    end
    wait_drawn();
    compare_framebuffer();

    // One steep or shallow line per octant from the centre
    for (int oct = 0; oct < 8; oct++) begin
      roll(r);
      len = 1 + int'(r[3:0]) % 15;
      mnr = int'(r[11:8]) % len;
      x0  = 1 << (HW - 1);
      y0  = 1 << (VW - 1);
      x1  = oct[0] ? x0 - (oct[2] ? mnr : len) : x0 + (oct[2] ? mnr : len);
      y1  = oct[1] ? y0 - (oct[2] ? len : mnr) : y0 + (oct[2] ? len : mnr);
      issue_cmd(gfx_cmd_pkg::OP_LINE, x0, y0, x1, y1, r[31:24]);
      cmd_valid = 1'b0;
      @(negedge clk);
    end
    // Random lines with every fourth horizontal and the next vertical
    for (int i = 0; i < 24; i++) begin
      roll(r);
      x0 = r[5:0];
      y0 = r[12:8];
      x1 = (i % 4 == 1) ? x0 : int'(r[21:16]);
      y1 = (i % 4 == 0) ? y0 : int'(r[28:24]);
      issue_cmd(gfx_cmd_pkg::OP_LINE, x0, y0, x1, y1, {r[31:29], r[7:6], r[15:13]});
      cmd_valid = 1'b0;
      @(negedge clk);
    end
    wait_drawn();
    compare_framebuffer();

    // Points ignore the second endpoint; zero-length lines draw one pixel
    for (int i = 0; i < 6; i++) begin
      roll(r);
      issue_cmd(gfx_cmd_pkg::OP_POINT, r[5:0], r[12:8], r[21:16], r[28:24], r[31:24]);
      wait_drawn();
      issue_cmd(gfx_cmd_pkg::OP_LINE, r[21:16], r[28:24], r[21:16], r[28:24], r[15:8]);
      wait_drawn();
    end
    compare_framebuffer();

    // XOR lines across existing content where a full row and column cross
    issue_cmd(gfx_cmd_pkg::OP_LINE_XOR, 0, 10, (1 << HW) - 1, 10, 8'h3c);
    issue_cmd(gfx_cmd_pkg::OP_LINE_XOR, 20, 0, 20, (1 << VW) - 1, 8'hc3);
    for (int i = 0; i < 8; i++) begin
      roll(r);
      op = r[0] ? gfx_cmd_pkg::OP_LINE_XOR : gfx_cmd_pkg::OP_POINT_XOR;
      issue_cmd(op, r[6:1], r[12:8], r[21:16], r[28:24], r[31:24]);
    end
    wait_drawn();
    compare_framebuffer();

    // Illegal opcodes mixed with legal lines
    for (int i = 0; i < 12; i++) begin
      roll(r);
      if (r[0]) begin
        op = gfx_cmd_pkg::opcode_t'({1'b1, r[2:1]});
      end else begin
        op = gfx_cmd_pkg::opcode_t'({1'b0, r[2:1]});
      end
      issue_cmd(op, r[8:3], r[13:9], r[19:14], r[24:20], r[31:24]);
      cmd_valid = 1'b0;
      @(negedge clk);
    end
    wait_drawn();
    compare_framebuffer();

    // Back-to-back stream with cmd_valid held high throughout
    for (int i = 0; i < 20; i++) begin
      roll(r);
      op = gfx_cmd_pkg::opcode_t'({(r[3:0] == 4'hf), r[1:0]});
      issue_cmd(op, r[9:4], r[14:10], r[20:15], r[25:21], {r[31:26], r[3:2]});
    end
    wait_drawn();
    compare_framebuffer();

    if (gfx_line_top_i.gfx_line_assertions_i.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("Concurrent assertions reported failures during the run");
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== gfx_line_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gfx_line_top #(
  parameter int H_WIDTH     = gfx_fb_pkg::H_WIDTH_DEF,
  parameter int V_WIDTH     = gfx_fb_pkg::V_WIDTH_DEF,
  parameter int PIXEL_WIDTH = gfx_fb_pkg::PIXEL_WIDTH_DEF
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  gfx_cmd_pkg::opcode_t   cmd_op,
  input  logic [H_WIDTH-1:0]     cmd_x0,
  input  logic [V_WIDTH-1:0]     cmd_y0,
  input  logic [H_WIDTH-1:0]     cmd_x1,
  input  logic [V_WIDTH-1:0]     cmd_y1,
  input  logic [PIXEL_WIDTH-1:0] cmd_color,
  input  logic [H_WIDTH-1:0]     rd_x,
  input  logic [V_WIDTH-1:0]     rd_y,
  output logic [PIXEL_WIDTH-1:0] rd_data,
  output logic [15:0]            pix_count,
  output logic [7:0]             err_count
);

  gfx_job_if #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) job_if ();

  gfx_pix_if #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) pix_if ();

  // Command port to job slot
  gfx_cmd_decode #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) gfx_cmd_decode_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_op   (cmd_op),
    .cmd_x0   (cmd_x0),
    .cmd_y0   (cmd_y0),
    .cmd_x1   (cmd_x1),
    .cmd_y1   (cmd_y1),
    .cmd_color(cmd_color),
    .err_count(err_count),
    .job      (job_if)
  );

  gfx_line_raster #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) gfx_line_raster_i (
    .clk  (clk),
    .rst_n(rst_n),
    .job  (job_if),
    .pix  (pix_if)
  );

  gfx_fb_writer #(
    .H_WIDTH    (H_WIDTH),
    .V_WIDTH    (V_WIDTH),
    .PIXEL_WIDTH(PIXEL_WIDTH)
  ) gfx_fb_writer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pix      (pix_if),
    .rd_x     (rd_x),
    .rd_y     (rd_y),
    .rd_data  (rd_data),
    .pix_count(pix_count)
  );

endmodule

`default_nettype wire

// ==== gfx_pix_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Single pixel write request
interface gfx_pix_if #(
  parameter int H_WIDTH     = gfx_fb_pkg::H_WIDTH_DEF,
  parameter int V_WIDTH     = gfx_fb_pkg::V_WIDTH_DEF,
  parameter int PIXEL_WIDTH = gfx_fb_pkg::PIXEL_WIDTH_DEF
);

  logic                   valid;
  logic                   ready;
  logic [H_WIDTH-1:0]     x;
  logic [V_WIDTH-1:0]     y;
  logic [PIXEL_WIDTH-1:0] pixel;
  gfx_fb_pkg::wr_mode_t   mode;

  modport src (
    output valid, x, y, pixel, mode,
    input  ready
  );

  modport dst (
    input  valid, x, y, pixel, mode,
    output ready
  );

endinterface

`default_nettype wire

// ==== sim.f ====
gfx_cmd_pkg.sv
gfx_fb_pkg.sv
gfx_job_if.sv
gfx_pix_if.sv
gfx_cmd_decode.sv
gfx_line_raster.sv
gfx_fb_writer.sv
gfx_line_top.sv
gfx_line_assertions.sv
gfx_line_tb.sv
